/* common/acc_cfg_pkg.sv */
`default_nettype none

package acc_cfg_pkg;

  // Data path
  localparam int DATA_W = 32;  // Buffer word and APB data
  localparam int COEF_W = 16;  // Unsigned coefficient

  // Output buffer geometry
  localparam int BUF_DEPTH = 256;
  localparam int BUF_AW    = 8;

  // Word count needs one bit more than the index to hold BUF_DEPTH itself
  localparam int CNT_W = BUF_AW + 1;

  // APB byte address
  localparam int APB_AW = 13;

endpackage

`default_nettype wire

/* common/acc_ctrl_pkg.sv */
`default_nettype none

package acc_ctrl_pkg;

  import acc_cfg_pkg::*;

  // Register byte offsets
  localparam logic [APB_AW-1:0] REG_CTRL   = 13'h000;  // Start, write one
  localparam logic [APB_AW-1:0] REG_STATUS = 13'h004;  // Busy and done, read only
  localparam logic [APB_AW-1:0] REG_COUNT  = 13'h008;
  localparam logic [APB_AW-1:0] REG_COEF   = 13'h00C;
  localparam logic [APB_AW-1:0] REG_OFFSET = 13'h010;

  // Bit positions
  localparam int CTRL_START_BIT = 0;
  localparam int STAT_BUSY_BIT  = 0;
  localparam int STAT_DONE_BIT  = 1;

  // Buffer window, one word per 4 bytes
  localparam logic [APB_AW-1:0] BUF_BASE = 13'h1000;
  localparam logic [APB_AW-1:0] BUF_END  = BUF_BASE + APB_AW'(4 * BUF_DEPTH);

  // Who holds the single-port buffer
  typedef enum logic [1:0] {
    OWN_IDLE    = 2'd0,
    OWN_ENGINE  = 2'd1,
    OWN_HOST_RD = 2'd2,
    OWN_HOST_WR = 2'd3
  } buf_owner_t;

endpackage

`default_nettype wire

/* out_buffer/out_buffer_sram.sv */
`timescale 1ns/10ps
`default_nettype none

module out_buffer_sram
  import acc_cfg_pkg::*;
(
  input  wire logic              clk,
  input  wire logic              cs_i,
  input  wire logic              we_i,
  input  wire logic [BUF_AW-1:0] idx_i,
  input  wire logic [DATA_W-1:0] wdata_i,
  output logic      [DATA_W-1:0] rdata_o
);

  logic [DATA_W-1:0] mem [BUF_DEPTH];

  // Write through cs with we, read otherwise
  always_ff @(posedge clk) begin
    if (cs_i && we_i) begin
      mem[idx_i] <= wdata_i;
    end
  end

  // Registered read, holds the last word until the next read
  always_ff @(posedge clk) begin
    if (cs_i && !we_i) begin
      rdata_o <= mem[idx_i];
    end
  end

endmodule

`default_nettype wire

/* out_buffer/out_buffer_wrapper.sv */
`timescale 1ns/10ps
`default_nettype none

module out_buffer_wrapper
  import acc_cfg_pkg::*;
  import acc_ctrl_pkg::*;
(
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire logic              start_i,
  input  wire logic              finish_i,
  // Engine side
  input  wire logic              eng_cs_i,
  input  wire logic              eng_we_i,
  input  wire logic [BUF_AW-1:0] eng_idx_i,
  input  wire logic [DATA_W-1:0] eng_wdata_i,
  output logic      [DATA_W-1:0] eng_rdata_o,
  // Host side, from the APB slave
  input  wire logic              host_req_i,
  input  wire logic              host_we_i,
  input  wire logic [BUF_AW-1:0] host_idx_i,
  input  wire logic [DATA_W-1:0] host_wdata_i,
  output logic                   host_ack_o,
  output logic      [DATA_W-1:0] host_rdata_o
);

  buf_owner_t state_q, state_d;

  logic              mem_cs;
  logic              mem_we;
  logic [BUF_AW-1:0] mem_idx;
  logic [DATA_W-1:0] mem_wdata;
  logic [DATA_W-1:0] mem_rdata;

  out_buffer_sram sram_inst (
    .clk    (clk),
    .cs_i   (mem_cs),
    .we_i   (mem_we),
    .idx_i  (mem_idx),
    .wdata_i(mem_wdata),
    .rdata_o(mem_rdata)
  );

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q <= OWN_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      OWN_IDLE: begin
        if (start_i) begin
          state_d = OWN_ENGINE;  // Engine wins over a host request
        end else if (host_req_i) begin
          state_d = host_we_i ? OWN_HOST_WR : OWN_HOST_RD;
        end
      end
      OWN_ENGINE: begin
        if (finish_i) begin
          state_d = OWN_IDLE;
        end
      end
      // Single cycle host states
      OWN_HOST_RD,
      OWN_HOST_WR: state_d = start_i ? OWN_ENGINE : OWN_IDLE;
      default:     state_d = OWN_IDLE;
    endcase
  end

  // Memory port and return data follow the owner
  always_comb begin
    mem_cs       = 1'b0;
    mem_we       = 1'b0;
    mem_idx      = '0;
    mem_wdata    = '0;
    eng_rdata_o  = '0;
    host_rdata_o = '0;
    host_ack_o   = 1'b0;
    case (state_q)
      OWN_ENGINE: begin
        mem_cs      = eng_cs_i;
        mem_we      = eng_we_i;
        mem_idx     = eng_idx_i;
        mem_wdata   = eng_wdata_i;
        eng_rdata_o = mem_rdata;
      end
      OWN_IDLE: begin
        // Host access issued straight from idle
        if (host_req_i && !start_i) begin
          mem_cs     = 1'b1;
          mem_we     = host_we_i;
          mem_idx    = host_idx_i;
          mem_wdata  = host_wdata_i;
          host_ack_o = host_we_i;  // Write is done this cycle
        end
      end
      OWN_HOST_RD: begin
        host_ack_o   = 1'b1;  // Read data back from memory
        host_rdata_o = mem_rdata;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/apb_acc_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module apb_acc_regs
  import acc_cfg_pkg::*;
  import acc_ctrl_pkg::*;
(
  input  wire logic              clk,
  input  wire logic              rst,
  // APB
  input  wire logic              psel_i,
  input  wire logic              penable_i,
  input  wire logic              pwrite_i,
  input  wire logic [APB_AW-1:0] paddr_i,
  input  wire logic [DATA_W-1:0] pwdata_i,
  output logic      [DATA_W-1:0] prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o,
  // Engine control
  output logic                   start_o,
  output logic      [CNT_W-1:0]  cfg_count_o,
  output logic      [COEF_W-1:0] cfg_coef_o,
  output logic      [DATA_W-1:0] cfg_offset_o,
  input  wire logic              finish_i,
  // Host buffer port
  output logic                   host_req_o,
  output logic                   host_we_o,
  output logic      [BUF_AW-1:0] host_idx_o,
  output logic      [DATA_W-1:0] host_wdata_o,
  input  wire logic              host_ack_i,
  input  wire logic [DATA_W-1:0] host_rdata_i
);

  logic       access;
  logic       is_buf;
  logic       is_reg;
  logic       reg_wr;
  buf_owner_t host_kind;  // Kind of buffer access in flight

  logic              start_q;
  logic              busy_q;
  logic              done_q;
  logic [CNT_W-1:0]  count_q;
  logic [COEF_W-1:0] coef_q;
  logic [DATA_W-1:0] offset_q;

  assign access = psel_i && penable_i;
  assign is_buf = (paddr_i >= BUF_BASE) && (paddr_i < BUF_END);

  always_comb begin
    case (paddr_i)
      REG_CTRL, REG_STATUS, REG_COUNT, REG_COEF, REG_OFFSET: is_reg = 1'b1;
      default: is_reg = 1'b0;
    endcase
  end

  always_comb begin
    host_kind = OWN_IDLE;
    if (access && is_buf) begin
      host_kind = pwrite_i ? OWN_HOST_WR : OWN_HOST_RD;
    end
  end

  assign host_req_o   = (host_kind != OWN_IDLE);
  assign host_we_o    = (host_kind == OWN_HOST_WR);
  assign host_idx_o   = paddr_i[BUF_AW+1:2];  // Word index
  assign host_wdata_o = pwdata_i;

  // Buffer accesses wait for the wrapper, everything else is zero wait
  assign pready_o  = access && (is_buf ? host_ack_i : 1'b1);
  assign pslverr_o = access && !is_buf && !is_reg;
  assign reg_wr    = access && pwrite_i && is_reg;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      start_q  <= 1'b0;
      busy_q   <= 1'b0;
      done_q   <= 1'b0;
      count_q  <= '0;
      coef_q   <= '0;
      offset_q <= '0;
    end else begin
      start_q <= 1'b0;
      if (reg_wr) begin
        case (paddr_i)
          REG_CTRL: begin
            if (pwdata_i[CTRL_START_BIT] && !busy_q) begin  // Ignored while busy
              start_q <= 1'b1;
              busy_q  <= 1'b1;
              done_q  <= 1'b0;
            end
          end
          REG_COUNT: begin
            // Clamp to the buffer size
            count_q <= (pwdata_i[CNT_W-1:0] > BUF_DEPTH) ? CNT_W'(BUF_DEPTH)
                                                          : pwdata_i[CNT_W-1:0];
          end
          REG_COEF:   coef_q   <= pwdata_i[COEF_W-1:0];
          REG_OFFSET: offset_q <= pwdata_i;
          default: ;
        endcase
      end
      if (finish_i) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
    end
  end

  always_comb begin
    prdata_o = '0;
    if (is_buf) begin
      prdata_o = host_rdata_i;
    end else begin
      case (paddr_i)
        REG_STATUS: begin
          prdata_o[STAT_BUSY_BIT] = busy_q;
          prdata_o[STAT_DONE_BIT] = done_q;
        end
        REG_COUNT:  prdata_o = DATA_W'(count_q);
        REG_COEF:   prdata_o = DATA_W'(coef_q);
        REG_OFFSET: prdata_o = offset_q;
        default: ;  // CTRL reads back 0
      endcase
    end
  end

  assign start_o      = start_q;
  assign cfg_count_o  = count_q;
  assign cfg_coef_o   = coef_q;
  assign cfg_offset_o = offset_q;

endmodule

`default_nettype wire

/* hdl/scale_engine.sv */
`timescale 1ns/10ps
`default_nettype none

module scale_engine
  import acc_cfg_pkg::*;
(
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire logic              start_i,
  input  wire logic [CNT_W-1:0]  count_i,
  input  wire logic [COEF_W-1:0] coef_i,
  input  wire logic [DATA_W-1:0] offset_i,
  output logic                   eng_cs_o,
  output logic                   eng_we_o,
  output logic      [BUF_AW-1:0] eng_idx_o,
  output logic      [DATA_W-1:0] eng_wdata_o,
  input  wire logic [DATA_W-1:0] eng_rdata_i,
  output logic                   finish_o
);

  typedef enum logic [1:0] {
    ENG_IDLE = 2'd0,
    ENG_RD   = 2'd1,
    ENG_CAP  = 2'd2,
    ENG_WR   = 2'd3
  } eng_state_t;

  eng_state_t state_q;

  logic [BUF_AW-1:0] idx_q;
  logic              finish_q;
  logic              last;

  logic [CNT_W-1:0]  count_q;
  logic [COEF_W-1:0] coef_q;
  logic [DATA_W-1:0] offset_q;
  logic [DATA_W-1:0] word_q;

  assign last = (CNT_W'(idx_q) + 1'b1) == count_q;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q  <= ENG_IDLE;
      idx_q    <= '0;
      finish_q <= 1'b0;
    end else begin
      finish_q <= 1'b0;
      case (state_q)
        ENG_IDLE: begin
          if (start_i) begin
            idx_q <= '0;
            if (count_i == '0) begin
              finish_q <= 1'b1;  // Nothing to do
            end else begin
              state_q <= ENG_RD;
            end
          end
        end
        ENG_RD:  state_q <= ENG_CAP;
        ENG_CAP: state_q <= ENG_WR;
        ENG_WR: begin
          if (last) begin
            state_q  <= ENG_IDLE;
            finish_q <= 1'b1;
          end else begin
            idx_q   <= idx_q + 1'b1;
            state_q <= ENG_RD;
          end
        end
        default: state_q <= ENG_IDLE;
      endcase
    end
  end

  // Config latched at start, word captured in the middle phase
  always_ff @(posedge clk) begin
    if (state_q == ENG_IDLE && start_i) begin
      count_q  <= count_i;
      coef_q   <= coef_i;
      offset_q <= offset_i;
    end
    if (state_q == ENG_CAP) begin
      word_q <= eng_rdata_i;
    end
  end

  assign eng_cs_o    = (state_q == ENG_RD) || (state_q == ENG_WR);
  assign eng_we_o    = (state_q == ENG_WR);
  assign eng_idx_o   = idx_q;
  assign eng_wdata_o = word_q * DATA_W'(coef_q) + offset_q;  // Lower 32 bits kept
  assign finish_o    = finish_q;

endmodule

`default_nettype wire

/* hdl/acc_top.sv */
`timescale 1ns/10ps
`default_nettype none

module acc_top
  import acc_cfg_pkg::*;
(
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire logic              psel_i,
  input  wire logic              penable_i,
  input  wire logic              pwrite_i,
  input  wire logic [APB_AW-1:0] paddr_i,
  input  wire logic [DATA_W-1:0] pwdata_i,
  output logic      [DATA_W-1:0] prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o
);

  logic              start;
  logic              finish;
  logic [CNT_W-1:0]  cfg_count;
  logic [COEF_W-1:0] cfg_coef;
  logic [DATA_W-1:0] cfg_offset;

  // Host port
  logic              host_req;
  logic              host_we;
  logic [BUF_AW-1:0] host_idx;
  logic [DATA_W-1:0] host_wdata;
  logic              host_ack;
  logic [DATA_W-1:0] host_rdata;

  // Engine port
  logic              eng_cs;
  logic              eng_we;
  logic [BUF_AW-1:0] eng_idx;
  logic [DATA_W-1:0] eng_wdata;
  logic [DATA_W-1:0] eng_rdata;

  apb_acc_regs regs_inst (
    .clk         (clk),
    .rst         (rst),
    .psel_i      (psel_i),
    .penable_i   (penable_i),
    .pwrite_i    (pwrite_i),
    .paddr_i     (paddr_i),
    .pwdata_i    (pwdata_i),
    .prdata_o    (prdata_o),
    .pready_o    (pready_o),
    .pslverr_o   (pslverr_o),
    .start_o     (start),
    .cfg_count_o (cfg_count),
    .cfg_coef_o  (cfg_coef),
    .cfg_offset_o(cfg_offset),
    .finish_i    (finish),
    .host_req_o  (host_req),
    .host_we_o   (host_we),
    .host_idx_o  (host_idx),
    .host_wdata_o(host_wdata),
    .host_ack_i  (host_ack),
    .host_rdata_i(host_rdata)
  );

  scale_engine engine_inst (
    .clk        (clk),
    .rst        (rst),
    .start_i    (start),
    .count_i    (cfg_count),
    .coef_i     (cfg_coef),
    .offset_i   (cfg_offset),
    .eng_cs_o   (eng_cs),
    .eng_we_o   (eng_we),
    .eng_idx_o  (eng_idx),
    .eng_wdata_o(eng_wdata),
    .eng_rdata_i(eng_rdata),
    .finish_o   (finish)
  );

  out_buffer_wrapper buf_inst (
    .clk         (clk),
    .rst         (rst),
    .start_i     (start),
    .finish_i    (finish),
    .eng_cs_i    (eng_cs),
    .eng_we_i    (eng_we),
    .eng_idx_i   (eng_idx),
    .eng_wdata_i (eng_wdata),
    .eng_rdata_o (eng_rdata),
    .host_req_i  (host_req),
    .host_we_i   (host_we),
    .host_idx_i  (host_idx),
    .host_wdata_i(host_wdata),
    .host_ack_o  (host_ack),
    .host_rdata_o(host_rdata)
  );

endmodule

`default_nettype wire

/* bench/acc_tb_tasks.svh */
// Setup phase then access phase until pready goes high
task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [DATA_W-1:0] data,
                         output logic err);
  int cycles;
  cycles = 0;
  @(negedge clk);
  psel    = 1'b1;
  penable = 1'b0;
  pwrite  = 1'b1;
  paddr   = addr;
  pwdata  = data;
  @(negedge clk);
  penable = 1'b1;
  #(CLK_PERIOD / 4);
  while (!pready && cycles < APB_TIMEOUT) begin
    @(negedge clk);
    #(CLK_PERIOD / 4);
    cycles++;
  end
  wait_cycles = cycles;
  err = pslverr;
  if (!pready) begin
    $display("Write to address %h never completed", addr);
    failures++;
  end
  @(negedge clk);  // Past the completing edge
  psel    = 1'b0;
  penable = 1'b0;
  pwrite  = 1'b0;
endtask

task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [DATA_W-1:0] data,
                        output logic err);
  int cycles;
  cycles = 0;
  @(negedge clk);
  psel    = 1'b1;
  penable = 1'b0;
  pwrite  = 1'b0;
  paddr   = addr;
  @(negedge clk);
  penable = 1'b1;
  #(CLK_PERIOD / 4);
  while (!pready && cycles < APB_TIMEOUT) begin
    @(negedge clk);
    #(CLK_PERIOD / 4);
    cycles++;
  end
  wait_cycles = cycles;
  data = prdata;
  err  = pslverr;
  if (!pready) begin
    $display("Read from address %h never completed", addr);
    failures++;
  end
  @(negedge clk);
  psel    = 1'b0;
  penable = 1'b0;
endtask

task automatic poll_done();
  logic [DATA_W-1:0] status;
  logic              err;
  int                polls;
  polls = 0;
  apb_read(REG_STATUS, status, err);
  while (status[STAT_DONE_BIT] !== 1'b1 && polls < POLL_LIMIT) begin
    apb_read(REG_STATUS, status, err);
    polls++;
  end
  if (status[STAT_DONE_BIT] !== 1'b1) begin
    $display("Engine did not report done within %0d polls", POLL_LIMIT);
    failures++;
  end
endtask

task automatic load_words(input int first, input int last);
  logic [DATA_W-1:0] w;
  logic              err;
  for (int i = first; i < last; i++) begin
    draw_word(w);
    apb_write(buf_addr(i), w, err);
    ref_mem[i] = w;
  end
endtask

task automatic check_buffer(input int first, input int last);
  logic [DATA_W-1:0] data;
  logic              err;
  for (int i = first; i < last; i++) begin
    apb_read(buf_addr(i), data, err);
    if (data !== ref_mem[i]) begin
      $display("Mismatch prdata_o at index %0d: got %h, expected %h", i, data, ref_mem[i]);
      mismatches++;
    end
    if (err !== 1'b0) begin
      $display("Mismatch pslverr_o at index %0d: got %h, expected %h", i, err, 1'b0);
      mismatches++;
    end
  end
endtask

task automatic start_run(input int count, input logic [15:0] coef, input logic [31:0] offset);
  logic err;
  apb_write(REG_COUNT, DATA_W'(count), err);
  apb_write(REG_COEF, {16'h0, coef}, err);
  apb_write(REG_OFFSET, offset, err);
  apb_write(REG_CTRL, 32'h1, err);
endtask

task automatic apply_scale(input int count, input logic [15:0] coef, input logic [31:0] offset);
  for (int i = 0; i < count; i++) begin
    ref_mem[i] = scale_word(ref_mem[i], coef, offset);
  end
endtask

task automatic test_registers();
  logic [DATA_W-1:0] data;
  logic [DATA_W-1:0] offset;
  logic              err;
  draw_word(offset);
  apb_read(REG_STATUS, data, err);
  if (data !== 32'h0) begin
    $display("Mismatch prdata_o on STATUS after reset: got %h, expected %h", data, 32'h0);
    mismatches++;
  end
  apb_write(REG_COUNT, 32'd37, err);
  apb_write(REG_COEF, 32'h1234BEEF, err);  // Upper half dropped
  apb_write(REG_OFFSET, offset, err);
  apb_read(REG_COUNT, data, err);
  if (data !== 32'd37) begin
    $display("Mismatch prdata_o on COUNT: got %h, expected %h", data, 32'd37);
    mismatches++;
  end
  apb_read(REG_COEF, data, err);
  if (data !== 32'h0000BEEF) begin
    $display("Mismatch prdata_o on COEF: got %h, expected %h", data, 32'h0000BEEF);
    mismatches++;
  end
  apb_read(REG_OFFSET, data, err);
  if (data !== offset || err !== 1'b0) begin
    $display("Mismatch prdata_o on OFFSET: got %h pslverr_o %h, expected %h pslverr_o 0",
             data, err, offset);
    mismatches++;
  end
  // Hole in the register map
  apb_write(13'h040, 32'hFFFFFFFF, err);
  if (err !== 1'b1) begin
    $display("Mismatch pslverr_o on unmapped write: got %h, expected %h", err, 1'b1);
    mismatches++;
  end
  apb_read(13'h040, data, err);
  if (err !== 1'b1 || data !== 32'h0) begin
    $display("Mismatch prdata_o on unmapped read: got %h pslverr_o %h, expected %h pslverr_o %h",
             data, err, 32'h0, 1'b1);
    mismatches++;
  end
endtask

task automatic test_buffer_window();
  logic [DATA_W-1:0] data;
  logic              err;
  int                idx;
  load_words(0, 16);
  for (int i = 0; i < 16; i++) begin
    idx = (i * 7) % 16;  // Shuffled visit order
    apb_read(buf_addr(idx), data, err);
    if (data !== ref_mem[idx] || err !== 1'b0) begin
      $display("Mismatch prdata_o at index %0d: got %h pslverr_o %h, expected %h pslverr_o 0",
               idx, data, err, ref_mem[idx]);
      mismatches++;
    end
  end
endtask

task automatic test_engine_result();
  logic [DATA_W-1:0] w;
  logic [DATA_W-1:0] offset;
  logic [15:0]       coef;
  load_words(0, 48);
  draw_word(w);
  coef = w[15:0];
  draw_word(offset);
  start_run(40, coef, offset);
  poll_done();
  apply_scale(40, coef, offset);
  check_buffer(0, 48);  // Words past the count stay as loaded
endtask

task automatic test_back_pressure();
  logic [DATA_W-1:0] data;
  logic [DATA_W-1:0] w;
  logic [DATA_W-1:0] offset;
  logic [15:0]       coef;
  logic              err;
  load_words(0, BUF_DEPTH);
  draw_word(w);
  coef = w[15:0];
  draw_word(offset);
  start_run(BUF_DEPTH, coef, offset);
  apb_read(REG_STATUS, data, err);
  if (data !== 32'h1) begin
    $display("Mismatch prdata_o on STATUS while running: got %h, expected %h", data, 32'h1);
    mismatches++;
  end
  apply_scale(BUF_DEPTH, coef, offset);
  apb_read(buf_addr(BUF_DEPTH - 1), data, err);  // Stalls behind the engine
  if (wait_cycles < MIN_STALL) begin
    $display("Buffer read finished after %0d wait cycles, engine should hold it for %0d",
             wait_cycles, MIN_STALL);
    failures++;
  end
  if (data !== ref_mem[BUF_DEPTH - 1]) begin
    $display("Mismatch prdata_o on stalled read: got %h, expected %h",
             data, ref_mem[BUF_DEPTH - 1]);
    mismatches++;
  end
  apb_read(REG_STATUS, data, err);
  if (data !== 32'h2) begin
    $display("Mismatch prdata_o on STATUS after run: got %h, expected %h", data, 32'h2);
    mismatches++;
  end
  check_buffer(0, BUF_DEPTH);
endtask

task automatic test_edge_cases();
  logic [DATA_W-1:0] data;
  logic [DATA_W-1:0] offset;
  logic [15:0]       coef;
  logic              err;
  // Empty run
  start_run(0, 16'h0003, 32'h11);
  poll_done();
  check_buffer(0, 16);
  // Second start during a run
  draw_word(data);
  coef = data[15:0];
  draw_word(offset);
  start_run(32, coef, offset);
  apb_write(REG_CTRL, 32'h1, err);
  poll_done();
  apply_scale(32, coef, offset);
  check_buffer(0, 40);
endtask

/* bench/acc_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module acc_tb
  import acc_cfg_pkg::*;
  import acc_ctrl_pkg::*;
();

  localparam int CLK_PERIOD  = 20;
  localparam int APB_TIMEOUT = 2000;  // Cycles in one access phase
  localparam int POLL_LIMIT  = 500;   // STATUS reads before giving up
  localparam int MIN_STALL   = 3 * BUF_DEPTH - 16;

  logic              clk;
  logic              rst;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [APB_AW-1:0] paddr;
  logic [DATA_W-1:0] pwdata;
  logic [DATA_W-1:0] prdata;
  logic              pready;
  logic              pslverr;

  // Model of the buffer contents
  logic [DATA_W-1:0] ref_mem [BUF_DEPTH];

  logic [31:0] lcg_state;
  int          mismatches;
  int          failures;
  int          wait_cycles;  // Wait states of the last access

  acc_top acc_top_inst (
    .clk      (clk),
    .rst      (rst),
    .psel_i   (psel),
    .penable_i(penable),
    .pwrite_i (pwrite),
    .paddr_i  (paddr),
    .pwdata_i (pwdata),
    .prdata_o (prdata),
    .pready_o (pready),
    .pslverr_o(pslverr)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic draw_word(output logic [31:0] w);
    lcg_state = lcg_step(lcg_state);
    w = lcg_state;
  endtask

  // Word times coefficient plus offset, lower 32 bits
  function automatic logic [31:0] scale_word(input logic [31:0] w, input logic [15:0] c,
                                             input logic [31:0] o);
    logic [63:0] prod;
    prod = w * c;
    return prod[31:0] + o;
  endfunction

  function automatic logic [APB_AW-1:0] buf_addr(input int idx);
    return BUF_BASE + APB_AW'(4 * idx);
  endfunction

  `include "acc_tb_tasks.svh"

  initial begin
    clk         = 1'b0;
    rst         = 1'b1;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    lcg_state   = 32'd36;
    mismatches  = 0;
    failures    = 0;
    wait_cycles = 0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    test_registers();
    test_buffer_window();
    test_engine_result();
    test_back_pressure();
    test_edge_cases();

    repeat (2) @(negedge clk);
    $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+bench
common/acc_cfg_pkg.sv
common/acc_ctrl_pkg.sv
out_buffer/out_buffer_sram.sv
out_buffer/out_buffer_wrapper.sv
hdl/apb_acc_regs.sv
hdl/scale_engine.sv
hdl/acc_top.sv
bench/acc_tb.sv

/* Bender.yml */
package:
  name: acc

sources:
  - files:
      - common/acc_cfg_pkg.sv
      - common/acc_ctrl_pkg.sv
      - out_buffer/out_buffer_sram.sv
      - out_buffer/out_buffer_wrapper.sv
      - hdl/apb_acc_regs.sv
      - hdl/scale_engine.sv
      - hdl/acc_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/acc_tb.sv
